// File: tests/exec_cluster_tests.txt
# I op data_1 data_2 src_1 src_2 valid_1 valid_2 rrn tag expected has_result, all hex
# F pulses delete_tag, E name expect_full closes a group
I 1 00001234 00004321 00 00 1 1 01 0 00005555 1
I 2 00000010 00000020 00 00 1 1 02 0 fffffff0 1
I 3 f0f0f0f0 0ff00ff0 00 00 1 1 03 0 00f000f0 1
I 4 f0000000 0000000f 00 00 1 1 04 0 f000000f 1
I 5 aaaaaaaa ffff0000 00 00 1 1 05 0 5555aaaa 1
I 6 ffffffff 00000001 00 00 1 1 06 0 00000001 1
I 6 00000005 fffffffe 00 00 1 1 07 0 00000000 1
I 7 00000003 00000024 00 00 1 1 08 0 00000030 1
I 8 80000000 0000001f 00 00 1 1 09 0 00000001 1
E alu_ops 0
I 9 00000003 00000005 00 00 1 1 0a 0 0000000f 1
I 9 00010000 00010000 00 00 1 1 0b 0 00000000 1
I 9 ffffffff 00000002 00 00 1 1 0c 0 fffffffe 1
I 9 12345678 00000010 00 00 1 1 0d 0 23456780 1
I 9 0000ffff 0000ffff 00 00 1 1 0e 0 fffe0001 1
E mul_ops 0
I 1 00000064 00000017 00 00 1 1 10 0 0000007b 1
I 9 00000000 00000002 10 00 0 1 11 0 000000f6 1
I 1 00000000 00000004 11 00 0 1 12 0 000000fa 1
I 4 00000000 00000100 12 00 0 1 13 0 000001fa 1
E deps 0
I 9 00000000 00000003 20 00 0 1 21 0 00000021 1
I 9 00000000 00000007 22 00 0 1 23 0 00000046 1
I 1 00000005 00000006 00 00 1 1 20 0 0000000b 1
I 2 00000000 00000001 20 00 0 1 22 0 0000000a 1
I 5 00000000 0000000f 21 00 0 1 24 0 0000002e 1
E cdb_clash 0
I 9 00000006 00000007 00 00 1 1 30 0 0000002a 1
I 1 00000000 00000001 33 00 0 1 31 0 00000052 1
I 1 00000001 00000001 00 00 1 1 32 1 00000000 0
I 9 00000000 00000002 31 00 0 1 34 1 00000000 0
F
I 9 00000009 00000009 00 00 1 1 33 0 00000051 1
I 2 00000032 00000008 00 00 1 1 35 0 0000002a 1
E flush 0
I 9 00000003 00000003 00 00 1 1 40 0 00000009 1
I 9 00000000 00000004 40 00 0 1 41 0 00000024 1
I 1 00000000 00000001 41 00 0 1 42 0 00000025 1
I 3 000000ff 0000000f 00 00 1 1 43 0 0000000f 1
I 4 00000010 00000001 00 00 1 1 44 0 00000011 1
I 7 00000001 00000008 00 00 1 1 45 0 00000100 1
I 8 00000100 00000004 00 00 1 1 46 0 00000010 1
I 2 00000007 00000007 00 00 1 1 47 0 00000000 1
E fill 1

// File: exec_cluster.f
logic/isa_pkg.sv
logic/core_pkg.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/exec_cluster.sv
tests/exec_cluster_tb.sv

// File: tests/exec_cluster_tb.sv
// exec cluster testbench
module exec_cluster_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RRN         = 2 ** core_pkg::RN_W;
  localparam int CYCLES_PER_LINE = 200;
  localparam int DRAIN_CYCLES    = 100;
  localparam int SETTLE_CYCLES   = 8;

  logic                      clock;
  logic                      arst_n;
  logic                      issue_valid;
  isa_pkg::opcode_e          issue_op;
  logic [core_pkg::XLEN-1:0] issue_data_1;
  logic [core_pkg::XLEN-1:0] issue_data_2;
  logic [core_pkg::RN_W-1:0] issue_src_1;
  logic [core_pkg::RN_W-1:0] issue_src_2;
  logic                      issue_valid_1;
  logic                      issue_valid_2;
  logic [core_pkg::RN_W-1:0] issue_rrn;
  logic                      issue_tag;
  logic                      delete_tag;
  logic                      issue_full;
  logic                      cdb_valid;
  logic [core_pkg::RN_W-1:0] cdb_rrn;
  logic [core_pkg::XLEN-1:0] cdb_data;

  // scoreboard, one slot per rename number.
  logic [core_pkg::XLEN-1:0] exp_data [NUM_RRN];
  logic                      pending  [NUM_RRN];
  int                        outstanding = 0;

  string       lines[$];
  logic [31:0] rng_state;
  logic        full_seen   = 1'b0;
  int          limit_cycles = 0;
  int          errors      = 0;
  int          group_start = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;

  exec_cluster #(
    .ALU_DEPTH (4),
    .MUL_DEPTH (4)
  ) u_exec_cluster (
    .clock         (clock),
    .arst_n        (arst_n),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_data_1  (issue_data_1),
    .issue_data_2  (issue_data_2),
    .issue_src_1   (issue_src_1),
    .issue_src_2   (issue_src_2),
    .issue_valid_1 (issue_valid_1),
    .issue_valid_2 (issue_valid_2),
    .issue_rrn     (issue_rrn),
    .issue_tag     (issue_tag),
    .delete_tag    (delete_tag),
    .issue_full    (issue_full),
    .cdb_valid     (cdb_valid),
    .cdb_rrn       (cdb_rrn),
    .cdb_data      (cdb_data)
  );

  // 4 ns period.
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one instruction, after zero or one idle cycle.
  task automatic issue_line(input string line);
    logic [31:0] op;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] rrn;
    logic [31:0] tag;
    logic [31:0] expd;
    logic [31:0] has;
    int          fields;
    fields = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h",
                     op, d1, d2, s1, s2, v1, v2, rrn, tag, expd, has);
    if (fields != 11) begin
      $display("unreadable stimulus line: %s", line);
      errors++;
    end else begin
      rng_state = xorshift32(rng_state);
      repeat (rng_state[0]) begin
        @(posedge clock);
        #1;
      end
      // hold off while either station is near full.
      while (issue_full) begin
        @(posedge clock);
        #1;
      end
      issue_op      = isa_pkg::opcode_e'(op[3:0]);
      issue_data_1  = d1;
      issue_data_2  = d2;
      issue_src_1   = s1[core_pkg::RN_W-1:0];
      issue_src_2   = s2[core_pkg::RN_W-1:0];
      issue_valid_1 = v1[0];
      issue_valid_2 = v2[0];
      issue_rrn     = rrn[core_pkg::RN_W-1:0];
      issue_tag     = tag[0];
      issue_valid   = 1'b1;
      if (has[0]) begin
        exp_data[rrn[core_pkg::RN_W-1:0]] = expd;
        pending[rrn[core_pkg::RN_W-1:0]]  = 1'b1;
        outstanding++;
      end
      @(posedge clock);
      #1 issue_valid = 1'b0;
    end
  endtask

  task automatic flush_pulse();
    delete_tag = 1'b1;
    @(posedge clock);
    #1 delete_tag = 1'b0;
  endtask

  // drain, list what never came, report the group.
  task automatic close_group(input string line);
    string       name;
    logic [31:0] want_full;
    int          waited;
    int          group_errors;
    if ($sscanf(line, "E %s %h", name, want_full) != 2) begin
      name      = "unnamed";
      want_full = '0;
    end
    waited = 0;
    while (outstanding > 0 && waited < DRAIN_CYCLES) begin
      @(posedge clock);
      #1;
      waited++;
    end
    // late squashed results would show up here.
    repeat (SETTLE_CYCLES) @(posedge clock);
    #1;
    for (int i = 0; i < NUM_RRN; i++) begin
      if (pending[i]) begin
        $display("result for rrn %0d never appeared on the bus", i);
        pending[i] = 1'b0;
        errors++;
      end
    end
    outstanding = 0;
    if (want_full[0] && !full_seen) begin
      $display("issue_full never rose while the station was being filled");
      errors++;
    end
    group_errors = errors - group_start;
    if (group_errors == 0) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: fail with %0d errors", name, group_errors);
    end
    group_start = errors;
    full_seen   = 1'b0;
  endtask

  // bus monitor, mid cycle.
  always @(negedge clock) begin
    if (arst_n === 1'b1) begin
      if (issue_full) begin
        full_seen = 1'b1;
      end
      if (cdb_valid) begin
        if (!pending[cdb_rrn]) begin
          $display("unexpected result for rrn %0d on the bus at %0t", cdb_rrn, $time);
          errors++;
        end else begin
          if (cdb_data !== exp_data[cdb_rrn]) begin
            $display("Mismatch at %0t: rrn %0d expected %h got %h",
                     $time, cdb_rrn, exp_data[cdb_rrn], cdb_data);
            errors++;
          end
          pending[cdb_rrn] = 1'b0;
          outstanding--;
        end
      end
    end
  end

  // watchdog, scaled by the stimulus length.
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("timeout after %0d cycles, the run did not finish", limit_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    int    fd;
    string line;
    byte   kind;
    arst_n        = 1'b1;
    issue_valid   = 1'b0;
    issue_op      = isa_pkg::OP_NONE;
    issue_data_1  = '0;
    issue_data_2  = '0;
    issue_src_1   = '0;
    issue_src_2   = '0;
    issue_valid_1 = 1'b0;
    issue_valid_2 = 1'b0;
    issue_rrn     = '0;
    issue_tag     = 1'b0;
    delete_tag    = 1'b0;
    rng_state     = 32'h1eaeffd0;
    for (int i = 0; i < NUM_RRN; i++) begin
      pending[i] = 1'b0;
    end
    fd = $fopen("tests/exec_cluster_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/exec_cluster_tests.txt");
      $display("Test failed");
      $finish;
    end else begin
      // keep command lines, drop comments and blanks.
      while ($fgets(line, fd) > 0) begin
        kind = line.getc(0);
        if (kind == "I" || kind == "F" || kind == "E") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      limit_cycles = CYCLES_PER_LINE * (lines.size() + 1);
      #1 arst_n = 1'b0;
      repeat (4) @(posedge clock);
      #1 arst_n = 1'b1;
      foreach (lines[n]) begin
        kind = lines[n].getc(0);
        case (kind)
          "I":     issue_line(lines[n]);
          "F":     flush_pulse();
          default: close_group(lines[n]);
        endcase
      end
      $display("groups passed %0d, groups failed %0d", pass_count, fail_count);
      if (errors == 0 && fail_count == 0 && pass_count > 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

// File: logic/exec_cluster.sv
// issue and execute cluster
module exec_cluster #(
  parameter int ALU_DEPTH = core_pkg::DEFAULT_DEPTH,
  parameter int MUL_DEPTH = core_pkg::DEFAULT_DEPTH
) (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      issue_valid,
  input  isa_pkg::opcode_e          issue_op,
  input  logic [core_pkg::XLEN-1:0] issue_data_1,
  input  logic [core_pkg::XLEN-1:0] issue_data_2,
  input  logic [core_pkg::RN_W-1:0] issue_src_1,
  input  logic [core_pkg::RN_W-1:0] issue_src_2,
  input  logic                      issue_valid_1,
  input  logic                      issue_valid_2,
  input  logic [core_pkg::RN_W-1:0] issue_rrn,
  input  logic                      issue_tag,
  input  logic                      delete_tag,
  output logic                      issue_full,
  output logic                      cdb_valid,
  output logic [core_pkg::RN_W-1:0] cdb_rrn,
  output logic [core_pkg::XLEN-1:0] cdb_data
);

  // alu path.
  logic                      alu_full;
  logic                      alu_disp_valid;
  isa_pkg::opcode_e          alu_disp_op;
  logic [core_pkg::XLEN-1:0] alu_disp_a;
  logic [core_pkg::XLEN-1:0] alu_disp_b;
  logic [core_pkg::RN_W-1:0] alu_disp_rrn;
  logic                      alu_next;
  logic                      alu_res_valid;
  logic [core_pkg::XLEN-1:0] alu_res_data;
  logic [core_pkg::RN_W-1:0] alu_res_rrn;
  logic                      alu_grant;

  // multiply path.
  logic                      mul_full;
  logic                      mul_disp_valid;
  logic [core_pkg::XLEN-1:0] mul_disp_a;
  logic [core_pkg::XLEN-1:0] mul_disp_b;
  logic [core_pkg::RN_W-1:0] mul_disp_rrn;
  logic                      mul_next;
  logic                      mul_res_valid;
  logic [core_pkg::XLEN-1:0] mul_res_data;
  logic [core_pkg::RN_W-1:0] mul_res_rrn;

  // issue stalls if either station is close to full.
  assign issue_full = alu_full | mul_full;

  reservation_station #(
    .SIZE       (ALU_DEPTH),
    .INSTR_TYPE (isa_pkg::TYPE_ALU)
  ) u_alu_station (
    .clock          (clock),
    .arst_n         (arst_n),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_data_1   (issue_data_1),
    .issue_data_2   (issue_data_2),
    .issue_src_1    (issue_src_1),
    .issue_src_2    (issue_src_2),
    .issue_valid_1  (issue_valid_1),
    .issue_valid_2  (issue_valid_2),
    .issue_rrn      (issue_rrn),
    .issue_tag      (issue_tag),
    .delete_tag     (delete_tag),
    .cdb_valid      (cdb_valid),
    .cdb_rrn        (cdb_rrn),
    .cdb_data       (cdb_data),
    .next           (alu_next),
    .dispatch_valid (alu_disp_valid),
    .dispatch_op    (alu_disp_op),
    .dispatch_a     (alu_disp_a),
    .dispatch_b     (alu_disp_b),
    .dispatch_rrn   (alu_disp_rrn),
    .full           (alu_full)
  );

  // opcode output unused, the multiplier has one operation.
  reservation_station #(
    .SIZE       (MUL_DEPTH),
    .INSTR_TYPE (isa_pkg::TYPE_MUL)
  ) u_mul_station (
    .clock          (clock),
    .arst_n         (arst_n),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_data_1   (issue_data_1),
    .issue_data_2   (issue_data_2),
    .issue_src_1    (issue_src_1),
    .issue_src_2    (issue_src_2),
    .issue_valid_1  (issue_valid_1),
    .issue_valid_2  (issue_valid_2),
    .issue_rrn      (issue_rrn),
    .issue_tag      (issue_tag),
    .delete_tag     (delete_tag),
    .cdb_valid      (cdb_valid),
    .cdb_rrn        (cdb_rrn),
    .cdb_data       (cdb_data),
    .next           (mul_next),
    .dispatch_valid (mul_disp_valid),
    .dispatch_op    (),
    .dispatch_a     (mul_disp_a),
    .dispatch_b     (mul_disp_b),
    .dispatch_rrn   (mul_disp_rrn),
    .full           (mul_full)
  );

  alu_unit u_alu_unit (
    .clock          (clock),
    .arst_n         (arst_n),
    .dispatch_valid (alu_disp_valid),
    .dispatch_op    (alu_disp_op),
    .dispatch_a     (alu_disp_a),
    .dispatch_b     (alu_disp_b),
    .dispatch_rrn   (alu_disp_rrn),
    .grant          (alu_grant),
    .next           (alu_next),
    .res_valid      (alu_res_valid),
    .res_data       (alu_res_data),
    .res_rrn        (alu_res_rrn)
  );

  mul_unit u_mul_unit (
    .clock          (clock),
    .arst_n         (arst_n),
    .dispatch_valid (mul_disp_valid),
    .dispatch_a     (mul_disp_a),
    .dispatch_b     (mul_disp_b),
    .dispatch_rrn   (mul_disp_rrn),
    .next           (mul_next),
    .res_valid      (mul_res_valid),
    .res_data       (mul_res_data),
    .res_rrn        (mul_res_rrn)
  );

  cdb_arbiter u_cdb_arbiter (
    .clock     (clock),
    .arst_n    (arst_n),
    .alu_valid (alu_res_valid),
    .alu_data  (alu_res_data),
    .alu_rrn   (alu_res_rrn),
    .mul_valid (mul_res_valid),
    .mul_data  (mul_res_data),
    .mul_rrn   (mul_res_rrn),
    .alu_grant (alu_grant),
    .cdb_valid (cdb_valid),
    .cdb_rrn   (cdb_rrn),
    .cdb_data  (cdb_data)
  );

endmodule

// File: logic/cdb_arbiter.sv
// common data bus arbiter
module cdb_arbiter (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      alu_valid,
  input  logic [core_pkg::XLEN-1:0] alu_data,
  input  logic [core_pkg::RN_W-1:0] alu_rrn,
  input  logic                      mul_valid,
  input  logic [core_pkg::XLEN-1:0] mul_data,
  input  logic [core_pkg::RN_W-1:0] mul_rrn,
  output logic                      alu_grant,
  output logic                      cdb_valid,
  output logic [core_pkg::RN_W-1:0] cdb_rrn,
  output logic [core_pkg::XLEN-1:0] cdb_data
);

  // alu only wins an idle multiplier slot.
  assign alu_grant = alu_valid && !mul_valid;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= mul_valid || alu_valid;
    end
  end

  // broadcast payload.
  // multiplier first, it has no place to hold a result.
  always_ff @(posedge clock) begin
    if (mul_valid) begin
      cdb_rrn  <= mul_rrn;
      cdb_data <= mul_data;
    end else begin
      cdb_rrn  <= alu_rrn;
      cdb_data <= alu_data;
    end
  end

endmodule

// File: logic/mul_unit.sv
// pipelined multiplier
module mul_unit (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      dispatch_valid,
  input  logic [core_pkg::XLEN-1:0] dispatch_a,
  input  logic [core_pkg::XLEN-1:0] dispatch_b,
  input  logic [core_pkg::RN_W-1:0] dispatch_rrn,
  output logic                      next,
  output logic                      res_valid,
  output logic [core_pkg::XLEN-1:0] res_data,
  output logic [core_pkg::RN_W-1:0] res_rrn
);

  // stage one, four 16x16 partial products.
  logic [31:0]               pp_ll;
  logic [31:0]               pp_lh;
  logic [31:0]               pp_hl;
  logic [31:0]               pp_hh;
  logic                      s1_valid;
  logic [core_pkg::RN_W-1:0] s1_rrn;

  // stage two, full product.
  logic [63:0]               s2_prod;
  logic                      s2_valid;
  logic [core_pkg::RN_W-1:0] s2_rrn;

  // never stalled, the arbiter always takes us first.
  assign next = 1'b1;

  // valid bits down the pipe.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid  <= dispatch_valid;
      s2_valid  <= s1_valid;
      res_valid <= s2_valid;
    end
  end

  // datapath.
  always_ff @(posedge clock) begin
    pp_ll  <= dispatch_a[15:0]  * dispatch_b[15:0];
    pp_lh  <= dispatch_a[15:0]  * dispatch_b[31:16];
    pp_hl  <= dispatch_a[31:16] * dispatch_b[15:0];
    pp_hh  <= dispatch_a[31:16] * dispatch_b[31:16];
    s1_rrn <= dispatch_rrn;

    // cross terms shift by 16, high term by 32.
    s2_prod <= {32'd0, pp_ll}
             + ({32'd0, pp_lh} << 16)
             + ({32'd0, pp_hl} << 16)
             + {pp_hh, 32'd0};
    s2_rrn  <= s1_rrn;

    // low word only.
    res_data <= s2_prod[31:0];
    res_rrn  <= s2_rrn;
  end

endmodule

// File: logic/alu_unit.sv
// single cycle integer alu
module alu_unit (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      dispatch_valid,
  input  isa_pkg::opcode_e          dispatch_op,
  input  logic [core_pkg::XLEN-1:0] dispatch_a,
  input  logic [core_pkg::XLEN-1:0] dispatch_b,
  input  logic [core_pkg::RN_W-1:0] dispatch_rrn,
  input  logic                      grant,
  output logic                      next,
  output logic                      res_valid,
  output logic [core_pkg::XLEN-1:0] res_data,
  output logic [core_pkg::RN_W-1:0] res_rrn
);

  logic [core_pkg::XLEN-1:0] result;

  // opcode rule.
  always_comb begin
    case (dispatch_op)
      isa_pkg::OP_ADD: result = dispatch_a + dispatch_b;
      isa_pkg::OP_SUB: result = dispatch_a - dispatch_b;
      isa_pkg::OP_AND: result = dispatch_a & dispatch_b;
      isa_pkg::OP_OR:  result = dispatch_a | dispatch_b;
      isa_pkg::OP_XOR: result = dispatch_a ^ dispatch_b;
      // signed compare, zero extended.
      isa_pkg::OP_SLT: result = core_pkg::XLEN'($signed(dispatch_a) < $signed(dispatch_b));
      isa_pkg::OP_SLL: result = dispatch_a << dispatch_b[4:0];
      isa_pkg::OP_SRL: result = dispatch_a >> dispatch_b[4:0];
      default:         result = '0;
    endcase
  end

  // free slot, or the held result leaves this edge.
  assign next = !res_valid || grant;

  // held result, valid until granted.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else if (dispatch_valid && next) begin
      res_valid <= 1'b1;
    end else if (grant) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_valid && next) begin
      res_data <= result;
      res_rrn  <= dispatch_rrn;
    end
  end

endmodule

// File: logic/reservation_station.sv
// in-order reservation station
module reservation_station #(
  parameter int                   SIZE       = core_pkg::DEFAULT_DEPTH,
  parameter isa_pkg::instr_type_e INSTR_TYPE = isa_pkg::TYPE_ALU
) (
  input  logic                      clock,
  input  logic                      arst_n,

  // issue side.
  input  logic                      issue_valid,
  input  isa_pkg::opcode_e          issue_op,
  input  logic [core_pkg::XLEN-1:0] issue_data_1,
  input  logic [core_pkg::XLEN-1:0] issue_data_2,
  input  logic [core_pkg::RN_W-1:0] issue_src_1,
  input  logic [core_pkg::RN_W-1:0] issue_src_2,
  input  logic                      issue_valid_1,
  input  logic                      issue_valid_2,
  input  logic [core_pkg::RN_W-1:0] issue_rrn,
  input  logic                      issue_tag,

  // flush and wakeup.
  input  logic                      delete_tag,
  input  logic                      cdb_valid,
  input  logic [core_pkg::RN_W-1:0] cdb_rrn,
  input  logic [core_pkg::XLEN-1:0] cdb_data,

  // unit side.
  input  logic                      next,
  output logic                      dispatch_valid,
  output isa_pkg::opcode_e          dispatch_op,
  output logic [core_pkg::XLEN-1:0] dispatch_a,
  output logic [core_pkg::XLEN-1:0] dispatch_b,
  output logic [core_pkg::RN_W-1:0] dispatch_rrn,
  output logic                      full
);

  localparam int IDX_W = $clog2(SIZE);
  localparam int CNT_W = IDX_W + 1;

  // entry records, one slice per field.
  logic [core_pkg::XLEN-1:0] data_1  [SIZE];
  logic [core_pkg::XLEN-1:0] data_2  [SIZE];
  logic [core_pkg::RN_W-1:0] src_1   [SIZE];
  logic [core_pkg::RN_W-1:0] src_2   [SIZE];
  logic [core_pkg::RN_W-1:0] rrn     [SIZE];
  isa_pkg::opcode_e          op      [SIZE];
  logic                      valid_1 [SIZE];
  logic                      valid_2 [SIZE];
  logic                      tag     [SIZE];
  logic                      skip    [SIZE];

  // queue pointers.
  logic [IDX_W-1:0] read_idx;
  logic [IDX_W-1:0] write_idx;
  logic [CNT_W-1:0] count;

  logic empty;
  logic head_ready;
  logic head_skip;
  logic push;
  logic pop;
  logic cap_1;
  logic cap_2;

  assign empty      = (count == '0);
  assign head_ready = valid_1[read_idx] && valid_2[read_idx];
  assign head_skip  = skip[read_idx];

  // only our own class, and a tagged issue dies with a flush in the same cycle.
  assign push = issue_valid
             && (isa_pkg::type_of(issue_op) == INSTR_TYPE)
             && !(delete_tag && issue_tag)
             && (count != CNT_W'(SIZE));

  // a skipped head leaves without a transfer.
  assign pop = !empty && (head_skip || (head_ready && next));

  // one free slot left already counts as full.
  assign full = (count >= CNT_W'(SIZE - 1));

  // head offer.
  assign dispatch_valid = !empty && !head_skip && head_ready;
  assign dispatch_op    = op[read_idx];
  assign dispatch_a     = data_1[read_idx];
  assign dispatch_b     = data_2[read_idx];
  assign dispatch_rrn   = rrn[read_idx];

  // operand already on the cdb while it is being issued.
  assign cap_1 = !issue_valid_1 && cdb_valid && (cdb_rrn == issue_src_1);
  assign cap_2 = !issue_valid_2 && cdb_valid && (cdb_rrn == issue_src_2);

  // pointers and occupancy.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      read_idx  <= '0;
      write_idx <= '0;
      count     <= '0;
    end else begin
      if (push) begin
        write_idx <= write_idx + 1'b1;
      end
      if (pop) begin
        read_idx <= read_idx + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // record updates.
  always_ff @(posedge clock) begin
    for (int i = 0; i < SIZE; i++) begin
      // wakeup from the broadcast.
      if (cdb_valid && !valid_1[i] && (src_1[i] == cdb_rrn)) begin
        data_1[i]  <= cdb_data;
        valid_1[i] <= 1'b1;
      end
      if (cdb_valid && !valid_2[i] && (src_2[i] == cdb_rrn)) begin
        data_2[i]  <= cdb_data;
        valid_2[i] <= 1'b1;
      end
      // squash of speculative entries.
      if (delete_tag && tag[i]) begin
        skip[i] <= 1'b1;
      end
    end
    // new entry, overrides anything above for this slot.
    if (push) begin
      data_1[write_idx]  <= cap_1 ? cdb_data : issue_data_1;
      data_2[write_idx]  <= cap_2 ? cdb_data : issue_data_2;
      valid_1[write_idx] <= issue_valid_1 || cap_1;
      valid_2[write_idx] <= issue_valid_2 || cap_2;
      src_1[write_idx]   <= issue_src_1;
      src_2[write_idx]   <= issue_src_2;
      rrn[write_idx]     <= issue_rrn;
      op[write_idx]      <= issue_op;
      tag[write_idx]     <= issue_tag;
      skip[write_idx]    <= 1'b0;
    end
  end

endmodule

// File: logic/core_pkg.sv
// core sizing constants
package core_pkg;

  // data word width.
  localparam int XLEN = 32;

  // register and rename number width.
  // 64 rename slots in total.
  localparam int RN_W = 6;

  // default entries per reservation station.
  // must stay a power of two for the index wrap.
  localparam int DEFAULT_DEPTH = 8;

endpackage

// File: logic/isa_pkg.sv
// instruction set encodings
package isa_pkg;

  // operation carried by every renamed instruction.
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLT  = 4'd6,
    OP_SLL  = 4'd7,
    OP_SRL  = 4'd8,
    OP_MUL  = 4'd9
  } opcode_e;

  // class picks the station and its unit.
  typedef enum logic [1:0] {
    TYPE_NONE = 2'd0,
    TYPE_ALU  = 2'd1,
    TYPE_MUL  = 2'd2
  } instr_type_e;

  // multiplies go to their own station, everything else to the alu.
  function automatic instr_type_e type_of(input opcode_e op);
    case (op)
      OP_NONE: return TYPE_NONE;
      OP_MUL:  return TYPE_MUL;
      default: return TYPE_ALU;
    endcase
  endfunction

endpackage
